/* logic/swm_pkg.sv */
/*
 * square-wave meter shared types
 * tick counts, per-channel result record, register map and meter states
 */
`default_nettype none

package swm_pkg;

    // channel count, the register map below is laid out for exactly two
    localparam integer NUM_CH = 2;

    // pll_clk ticks, wraps after 2^32
    typedef logic [31:0] tick_t;

    // wishbone address and data
    typedef logic [7:0]  wb_addr_t;  // byte address
    typedef logic [31:0] wb_data_t;

    // one finished window
    typedef struct packed {
        tick_t period_ticks;    // end stamp minus start stamp
        tick_t high_ticks;      // synchronized-high cycles in the window
    } meas_result_t;

    // register map, all word aligned
    localparam wb_addr_t ADDR_CH0_PERIOD = 8'h00;
    localparam wb_addr_t ADDR_CH0_HIGH   = 8'h04;
    localparam wb_addr_t ADDR_CH1_PERIOD = 8'h08;
    localparam wb_addr_t ADDR_CH1_HIGH   = 8'h0C;
    localparam wb_addr_t ADDR_STATUS     = 8'h10;  // [3:2] overrun, [1:0] fresh
    localparam wb_addr_t ADDR_CONTROL    = 8'h14;  // [1:0] channel enables

    // per-channel window FSM
    typedef enum logic [1:0] {
        M_IDLE   = 2'd0,    // waiting for the first rising edge
        M_WINDOW = 2'd1,    // counting periods
        M_OFF    = 2'd2     // channel disabled
    } meter_state_t;

endpackage : swm_pkg

`default_nettype wire

/* logic/wave_meter.sv */
/*
 * wave_meter, one measurement channel
 * synchronizes the input, stamps rising edges against a free-running
 * counter and reports period and high time over CYCLES_PER_WINDOW periods
 */
`timescale 1ns/1ns
`default_nettype none

module wave_meter
    import swm_pkg::*;
#(
    parameter integer CYCLES_PER_WINDOW = 4     // 1 .. 255
) (
    input  wire logic    pll_clk,
    input  wire logic    sys_rst_n,
    input  wire logic    wave,          // async square wave
    input  wire logic    enable,
    output meas_result_t result,
    output logic         result_valid   // one-cycle pulse
);

    // edge number that closes the window, counted from 0
    localparam logic [7:0] LAST_EDGE = 8'(CYCLES_PER_WINDOW - 1);

    logic [2:0]   sync_q;       // [1:0] synchronizer, [2] edge register
    logic         hi;
    logic         rise;
    tick_t        ts;           // free-running timestamp
    tick_t        start_ts;     // stamp of the edge that opened the window
    tick_t        high_acc;
    logic [7:0]   edge_cnt;     // rising edges seen in the window
    meter_state_t state;
    logic         open_win;
    logic         close_win;

    // hi and rise come from the same stage, so both see the same delay
    assign hi   = sync_q[1];
    assign rise = sync_q[1] & ~sync_q[2];

    assign open_win  = (state == M_IDLE) && enable && rise;
    assign close_win = (state == M_WINDOW) && enable && rise && (edge_cnt == LAST_EDGE);

    always_ff @(posedge pll_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            sync_q <= '0;
            ts     <= '0;
        end else begin
            sync_q <= {sync_q[1:0], wave};
            ts     <= ts + tick_t'(1);  // wraps, difference stays valid
        end
    end

    // window FSM
    always_ff @(posedge pll_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state        <= M_IDLE;
            edge_cnt     <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= 1'b0;
            case (state)
                M_OFF: begin
                    edge_cnt <= '0;
                    if (enable)
                        state <= M_IDLE;    // fresh window on next edge
                end
                M_IDLE: begin
                    if (!enable) begin
                        state <= M_OFF;
                    end else if (rise) begin
                        state    <= M_WINDOW;
                        edge_cnt <= '0;
                    end
                end
                M_WINDOW: begin
                    if (!enable) begin
                        state    <= M_OFF;
                        edge_cnt <= '0;     // drop the partial window
                    end else if (close_win) begin
                        edge_cnt     <= '0; // closing edge opens the next one
                        result_valid <= 1'b1;
                    end else if (rise) begin
                        edge_cnt <= edge_cnt + 8'd1;
                    end
                end
                default: state <= M_IDLE;
            endcase
        end
    end

    // timestamps and accumulators
    always_ff @(posedge pll_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            start_ts <= '0;
            high_acc <= '0;
            result   <= '0;
        end else begin
            if (open_win || close_win) begin
                start_ts <= ts;
                high_acc <= tick_t'(1);     // the edge cycle itself is high
            end else if (state == M_WINDOW) begin
                high_acc <= high_acc + tick_t'(hi);
            end else if (state == M_OFF) begin
                high_acc <= '0;
            end

            if (close_win) begin
                result.period_ticks <= ts - start_ts;  // modular 32-bit
                result.high_ticks   <= high_acc;       // excludes closing cycle
            end
        end
    end

endmodule : wave_meter

`default_nettype wire

/* logic/meas_regs.sv */
/*
 * meas_regs, Wishbone classic register block
 * latest result per channel, fresh/overrun status and channel enables
 */
`timescale 1ns/1ns
`default_nettype none

module meas_regs
    import swm_pkg::*;
(
    input  wire logic         pll_clk,
    input  wire logic         sys_rst_n,
    // wishbone classic slave
    input  wire logic         wb_cyc,
    input  wire logic         wb_stb,
    input  wire logic         wb_we,
    input  wire wb_addr_t     wb_adr,
    input  wire wb_data_t     wb_dat_w,
    output wb_data_t          wb_dat_r,
    output logic              wb_ack,
    // meter results
    input  wire meas_result_t ch0_result,
    input  wire logic         ch0_valid,
    input  wire meas_result_t ch1_result,
    input  wire logic         ch1_valid,
    output logic [NUM_CH-1:0] enable
);

    meas_result_t      in_res [NUM_CH];
    logic [NUM_CH-1:0] in_valid;
    meas_result_t      res_q [NUM_CH];   // last result per channel
    logic [NUM_CH-1:0] fresh;            // unread result waiting
    logic [NUM_CH-1:0] overrun;          // result replaced before read
    logic              req;
    logic              rd_req;
    logic              wr_req;
    logic [NUM_CH-1:0] rd_period;
    logic              rd_status;
    wb_data_t          rd_data;

    assign in_res[0] = ch0_result;
    assign in_res[1] = ch1_result;
    assign in_valid  = {ch1_valid, ch0_valid};

    // new request only while ack is low, gives one ack per access
    assign req    = wb_cyc & wb_stb & ~wb_ack;
    assign rd_req = req & ~wb_we;
    assign wr_req = req & wb_we;

    // read side effects
    assign rd_period[0] = rd_req && (wb_adr == ADDR_CH0_PERIOD);
    assign rd_period[1] = rd_req && (wb_adr == ADDR_CH1_PERIOD);
    assign rd_status    = rd_req && (wb_adr == ADDR_STATUS);

    always_comb begin
        case (wb_adr)
            ADDR_CH0_PERIOD: rd_data = res_q[0].period_ticks;
            ADDR_CH0_HIGH:   rd_data = res_q[0].high_ticks;
            ADDR_CH1_PERIOD: rd_data = res_q[1].period_ticks;
            ADDR_CH1_HIGH:   rd_data = res_q[1].high_ticks;
            ADDR_STATUS:     rd_data = wb_data_t'({overrun, fresh});
            ADDR_CONTROL:    rd_data = wb_data_t'(enable);
            default:         rd_data = '0;  // unmapped
        endcase
    end

    // bus handshake and control register
    always_ff @(posedge pll_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            wb_ack   <= 1'b0;
            wb_dat_r <= '0;
            enable   <= '1;     // both channels run from reset
        end else begin
            wb_ack <= req;      // one cycle after the sampled request
            if (req)
                wb_dat_r <= wb_we ? '0 : rd_data;
            if (wr_req && (wb_adr == ADDR_CONTROL))
                enable <= wb_dat_w[NUM_CH-1:0];
            // writes elsewhere are acked and dropped
        end
    end

    // result capture and status flags, a new result beats a same-cycle clear
    always_ff @(posedge pll_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            fresh   <= '0;
            overrun <= '0;
            for (int i = 0; i < NUM_CH; i++)
                res_q[i] <= '0;
        end else begin
            for (int i = 0; i < NUM_CH; i++) begin
                if (in_valid[i]) begin
                    res_q[i] <= in_res[i];  // always accepted
                    fresh[i] <= 1'b1;
                end else if (rd_period[i]) begin
                    fresh[i] <= 1'b0;
                end

                if (in_valid[i] && fresh[i])
                    overrun[i] <= 1'b1;     // previous one never read
                else if (rd_status)
                    overrun[i] <= 1'b0;
            end
        end
    end

endmodule : meas_regs

`default_nettype wire

/* logic/square_wave_meter.sv */
/*
 * square_wave_meter top level
 * two channel meters feeding one Wishbone register block
 */
`timescale 1ns/1ns
`default_nettype none

module square_wave_meter
    import swm_pkg::*;
#(
    parameter integer CYCLES_PER_WINDOW = 4     // periods per window
) (
    input  wire logic              pll_clk,
    input  wire logic              sys_rst_n,
    input  wire logic [NUM_CH-1:0] wave_in,     // async to pll_clk
    // wishbone classic slave
    input  wire logic              wb_cyc,
    input  wire logic              wb_stb,
    input  wire logic              wb_we,
    input  wire wb_addr_t          wb_adr,
    input  wire wb_data_t          wb_dat_w,
    output wb_data_t               wb_dat_r,
    output logic                   wb_ack
);

    meas_result_t      ch0_result;
    meas_result_t      ch1_result;
    logic              ch0_valid;
    logic              ch1_valid;
    logic [NUM_CH-1:0] enable;      // from the control register

    wave_meter #(
        .CYCLES_PER_WINDOW(CYCLES_PER_WINDOW)
    ) u_meter0 (
        .pll_clk      (pll_clk),
        .sys_rst_n    (sys_rst_n),
        .wave         (wave_in[0]),
        .enable       (enable[0]),
        .result       (ch0_result),
        .result_valid (ch0_valid)
    );

    wave_meter #(
        .CYCLES_PER_WINDOW(CYCLES_PER_WINDOW)
    ) u_meter1 (
        .pll_clk      (pll_clk),
        .sys_rst_n    (sys_rst_n),
        .wave         (wave_in[1]),
        .enable       (enable[1]),
        .result       (ch1_result),
        .result_valid (ch1_valid)
    );

    meas_regs u_regs (
        .pll_clk    (pll_clk),
        .sys_rst_n  (sys_rst_n),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .ch0_result (ch0_result),
        .ch0_valid  (ch0_valid),
        .ch1_result (ch1_result),
        .ch1_valid  (ch1_valid),
        .enable     (enable)
    );

endmodule : square_wave_meter

`default_nettype wire

/* dv/tb_clkgen.sv */
/*
 * testbench clock and reset source
 * 100 ns pll_clk, reset held low for the first 10 cycles
 */
`timescale 1ns/1ns
`default_nettype none

module tb_clkgen (
    output logic pll_clk,
    output logic sys_rst_n
);

    initial begin
        pll_clk = 1'b0;
        forever #50 pll_clk = ~pll_clk;    // 100 ns period
    end

    initial begin
        sys_rst_n = 1'b0;
        repeat (10) @(posedge pll_clk);
        sys_rst_n <= 1'b1;                 // release on a clock edge
    end

endmodule : tb_clkgen

`default_nettype wire

/* dv/square_wave_meter_checker.sv */
/*
 * Wishbone handshake and reset assertions for meas_regs
 */
`timescale 1ns/1ns
`default_nettype none

module square_wave_meter_checker (
    input wire logic pll_clk,
    input wire logic sys_rst_n,
    input wire logic wb_cyc,
    input wire logic wb_stb,
    input wire logic wb_ack
);

    int fail_count = 0;     // failed assertions so far

    // ack only answers a strobed cycle
    a_ack_has_req: assert property (@(posedge pll_clk) disable iff (!sys_rst_n)
        wb_ack |-> $past(wb_cyc && wb_stb))
        else begin
            $error("wb_ack without a request in the previous cycle");
            fail_count++;
        end

    // single-cycle ack
    a_ack_single: assert property (@(posedge pll_clk) disable iff (!sys_rst_n)
        wb_ack |=> !wb_ack)
        else begin
            $error("wb_ack high for two cycles");
            fail_count++;
        end

    a_ack_latency: assert property (@(posedge pll_clk) disable iff (!sys_rst_n)
        (wb_cyc && wb_stb && !wb_ack) |=> wb_ack)
        else begin
            $error("wb_ack did not follow the request after one cycle");
            fail_count++;
        end

    // no disable here, reset itself is checked
    a_ack_reset: assert property (@(posedge pll_clk) !sys_rst_n |-> !wb_ack)
        else begin
            $error("wb_ack high during reset");
            fail_count++;
        end

endmodule : square_wave_meter_checker

bind meas_regs square_wave_meter_checker u_checker (
    .pll_clk   (pll_clk),
    .sys_rst_n (sys_rst_n),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_ack    (wb_ack)
);

`default_nettype wire

/* dv/tb_square_wave_meter.sv */
/*
 * testbench for square_wave_meter
 * two wave generators, Wishbone bus tasks, six directed and random tests
 */
`timescale 1ns/1ns
`default_nettype none

module tb_square_wave_meter
    import swm_pkg::*;
;
    localparam int WIN = 4;                                // periods per window
    localparam longint WATCHDOG_NS = 6 * 6 * (4 * 32) * 100;

    logic        pll_clk, sys_rst_n;
    logic [1:0]  wave_in;
    logic        wb_cyc, wb_stb, wb_we, wb_ack;
    wb_addr_t    wb_adr;
    wb_data_t    wb_dat_w, wb_dat_r;
    int          gen_p [2] = '{10, 10};                    // period in cycles
    int          gen_h [2] = '{3, 3};                      // high time in cycles
    logic [31:0] lfsr = 32'he267_2d90;
    int          errors = 0;
    int          failed_tests = 0;
    int          test_err;
    wb_data_t    st, old_p, old_h, rd_v;

    tb_clkgen u_clkgen (.pll_clk(pll_clk), .sys_rst_n(sys_rst_n));

    square_wave_meter #(.CYCLES_PER_WINDOW(WIN)) u_square_wave_meter (
        .pll_clk(pll_clk), .sys_rst_n(sys_rst_n), .wave_in(wave_in),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
    );

    // one generator per channel, high for the first H cycles of each period
    for (genvar g = 0; g < 2; g++) begin : gen_wave
        int   cnt = 0;
        logic wave_q = 1'b0;
        assign wave_in[g] = wave_q;
        always @(posedge pll_clk) begin
            if (cnt >= gen_p[g] - 1)
                cnt = 0;
            else
                cnt = cnt + 1;
            wave_q <= (cnt < gen_h[g]);
        end
    end

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    task automatic pick_wave(input int ch);
        gen_p[ch] = 6 + rand_bits(4);                      // 6 .. 21
        gen_h[ch] = 1 + (rand_bits(5) % (gen_p[ch] - 1));  // 1 .. P-1
    endtask

    task automatic bus_access(input logic we, input wb_addr_t adr, input wb_data_t wdat,
                              output wb_data_t rdat);
        int n;
        n = 0;
        @(posedge pll_clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdat;
        do begin
            @(posedge pll_clk);
            n++;
        end while (!wb_ack && n < 16);
        if (!wb_ack) begin
            $display("no wb_ack at address 0x%02h within 16 cycles", adr);
            errors++;
        end
        rdat = wb_dat_r;                                   // valid with ack
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic rd(input wb_addr_t adr, output wb_data_t v);
        bus_access(1'b0, adr, '0, v);
    endtask

    task automatic wr(input wb_addr_t adr, input wb_data_t v);
        wb_data_t dummy;
        bus_access(1'b1, adr, v, dummy);
    endtask

    task automatic check_val(input string name, input wb_data_t exp, input wb_data_t got);
        assert (got == exp) else begin
            $display("ERR %s expected 0x%08h got 0x%08h", name, exp, got);
            errors++;
        end
    endtask

    task automatic read_check(input string name, input wb_addr_t adr, input wb_data_t exp);
        wb_data_t v;
        rd(adr, v);
        check_val(name, exp, v);
    endtask

    // poll STATUS until the channel's fresh bit sets
    task automatic wait_fresh(input int ch);
        wb_data_t s;
        int n;
        n = 0;
        do begin
            rd(ADDR_STATUS, s);
            n++;
        end while (!s[ch] && n < 200);
        if (!s[ch]) begin
            $display("channel %0d never reported a fresh result", ch);
            errors++;
        end
    endtask

    // drop every window that may straddle a waveform change
    task automatic settle(input int ch, input wb_addr_t per_adr);
        wb_data_t v;
        repeat (3) begin
            rd(per_adr, v);                                // clears fresh
            wait_fresh(ch);
        end
    endtask

    task automatic end_test(input int num, input string name);
        if (errors != test_err)
            failed_tests++;
        $display("test %0d %s: %s", num, name, (errors == test_err) ? "ok" : "failed");
        test_err = errors;
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("simulation timed out after %0d ns", WATCHDOG_NS);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        test_err = 0;
        wait (sys_rst_n === 1'b1);

        read_check("STATUS", ADDR_STATUS, 32'h0);          // 1 reset state
        read_check("CH0_PERIOD", ADDR_CH0_PERIOD, 32'h0);
        read_check("CH1_HIGH", ADDR_CH1_HIGH, 32'h0);
        read_check("CONTROL", ADDR_CONTROL, 32'h3);
        end_test(1, "reset state");

        wait_fresh(0);                                     // 2 P=10 H=3
        read_check("CH0_PERIOD", ADDR_CH0_PERIOD, 32'h28);
        read_check("CH0_HIGH", ADDR_CH0_HIGH, 32'h0C);
        end_test(2, "channel 0 measurement");

        pick_wave(0);                                      // 3 random pair
        pick_wave(1);
        if (gen_p[1] == gen_p[0]) begin
            gen_p[1] = (gen_p[1] == 21) ? 6 : gen_p[1] + 1;
            if (gen_h[1] >= gen_p[1])
                gen_h[1] = gen_p[1] - 1;                   // keep a low phase
        end
        settle(0, ADDR_CH0_PERIOD);
        read_check("CH0_PERIOD", ADDR_CH0_PERIOD, WIN * gen_p[0]);
        read_check("CH0_HIGH", ADDR_CH0_HIGH, WIN * gen_h[0]);
        settle(1, ADDR_CH1_PERIOD);
        read_check("CH1_PERIOD", ADDR_CH1_PERIOD, WIN * gen_p[1]);
        read_check("CH1_HIGH", ADDR_CH1_HIGH, WIN * gen_h[1]);
        end_test(3, "side-by-side channels");

        wait_fresh(1);                                     // 4 flags
        rd(ADDR_CH1_PERIOD, rd_v);
        rd(ADDR_STATUS, st);
        check_val("STATUS.fresh1", 32'h0, {31'd0, st[1]});
        wait_fresh(1);
        repeat (10 * gen_p[1]) @(posedge pll_clk);         // two more windows, no read
        rd(ADDR_STATUS, st);
        check_val("STATUS.fresh1", 32'h1, {31'd0, st[1]});
        check_val("STATUS.overrun1", 32'h1, {31'd0, st[3]});
        rd(ADDR_STATUS, st);
        check_val("STATUS.overrun1", 32'h0, {31'd0, st[3]});
        end_test(4, "fresh and overrun flags");

        wr(ADDR_CONTROL, 32'h1);                           // 5 enable control
        repeat (4) @(posedge pll_clk);                     // let an in-flight result land
        rd(ADDR_CH1_PERIOD, old_p);
        rd(ADDR_CH1_HIGH, old_h);
        pick_wave(1);
        repeat (3 * WIN * 21) @(posedge pll_clk);
        rd(ADDR_STATUS, st);
        check_val("STATUS.fresh1", 32'h0, {31'd0, st[1]});
        read_check("CH1_PERIOD", ADDR_CH1_PERIOD, old_p);
        read_check("CH1_HIGH", ADDR_CH1_HIGH, old_h);
        read_check("CONTROL", ADDR_CONTROL, 32'h1);
        wr(ADDR_CONTROL, 32'h3);
        wait_fresh(1);                                     // first window is whole
        read_check("CH1_PERIOD", ADDR_CH1_PERIOD, WIN * gen_p[1]);
        read_check("CH1_HIGH", ADDR_CH1_HIGH, WIN * gen_h[1]);
        wr(ADDR_CH0_PERIOD, 32'hFFFF_FFFF);                // read-only, dropped
        read_check("CH0_PERIOD", ADDR_CH0_PERIOD, WIN * gen_p[0]);
        end_test(5, "enable control");

        read_check("UNMAPPED_20", 8'h20, 32'h0);           // 6 bus protocol
        end_test(6, "bus protocol");

        errors += u_square_wave_meter.u_regs.u_checker.fail_count;  // bound assertions
        $display("tests: 6, failed: %0d, errors: %0d", failed_tests, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule : tb_square_wave_meter

`default_nettype wire

/* flist.f */
logic/swm_pkg.sv
logic/wave_meter.sv
logic/meas_regs.sv
logic/square_wave_meter.sv
dv/tb_clkgen.sv
dv/square_wave_meter_checker.sv
dv/tb_square_wave_meter.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= tb_square_wave_meter
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
